//--- rtl/board_defs.svh
`ifndef BOARD_DEFS_SVH
`define BOARD_DEFS_SVH

// ---------------------------------------------------------------------------
// Board clock and lanes
// ---------------------------------------------------------------------------

`define CLK_MHZ         27      // Board oscillator
`define W_LANE          8       // Digits, LEDs and meter lanes

// ---------------------------------------------------------------------------
// Serial dividers, in system clocks per half period
// ---------------------------------------------------------------------------

`define I2S_SCK_DIV     4       // Microphone bit clock
`define SIO_CLK_DIV     1       // TM1638 serial clock

// ---------------------------------------------------------------------------
// Meter behavior
// ---------------------------------------------------------------------------

`define HOLD_SAMPLES    4       // Peak hold, in samples
`define LANE_STEP_LOG2  20      // Threshold step between lanes

`endif

//--- rtl/board_pkg.sv
`default_nettype none

package board_pkg;

    // Microphone word, two's complement
    typedef logic signed [23:0] sample_t;

    // ---------------------------------------------------------------------------
    // TM1638 command and data bytes
    // ---------------------------------------------------------------------------

    // Command class sits in the top two bits of a command byte
    typedef enum logic [1:0]
    {
        tm_kind_data    = 2'b01,    // Data write mode
        tm_kind_display = 2'b10,    // Display on and brightness
        tm_kind_address = 2'b11     // Start address
    } tm_kind_e;

    typedef struct packed
    {
        tm_kind_e   kind;
        logic [5:0] field;          // Mode bits, address or brightness
    } tm_cmd_t;

    // Same byte on the wire, decoded as command or as segments
    typedef union packed
    {
        tm_cmd_t    cmd;
        logic [7:0] hgfedcba;       // Bit 0 is segment a
    } tm_byte_t;

endpackage

`default_nettype wire

//--- rtl/inmp441_mic_i2s_receiver.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_defs.svh"

module inmp441_mic_i2s_receiver
(
    input  wire                 clk,
    input  wire                 rst_n,

    output logic                sck,
    output logic                ws,
    output logic                lr,
    input  wire                 sd,

    output board_pkg::sample_t  sample,
    output logic                sample_valid
);

    localparam int div_w     = (`I2S_SCK_DIV > 1) ? $clog2(`I2S_SCK_DIV) : 1;
    localparam int first_bit = 1;   // MSB follows ws by one sck period
    localparam int last_bit  = 24;

    logic [div_w - 1:0] div_cnt;
    logic [5:0]         bit_cnt;    // sck period within the frame
    logic               tick;
    logic               capture;
    logic [22:0]        shift;

    assign tick    = (div_cnt == div_w'(`I2S_SCK_DIV - 1));
    assign capture = tick && !sck                       // Rising sck
                     && (bit_cnt >= 6'(first_bit))
                     && (bit_cnt <= 6'(last_bit));

    assign ws = bit_cnt[5];         // Low for the left half
    assign lr = 1'b0;               // Mic answers in the left slot

    // ---------------------------------------------------------------------------
    // Clock generation
    // ---------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            div_cnt      <= '0;
            sck          <= 1'b0;
            bit_cnt      <= '0;
            sample_valid <= 1'b0;
        end
        else
        begin
            sample_valid <= 1'b0;

            if (tick)
            begin
                div_cnt <= '0;
                sck     <= ~sck;

                if (sck)
                    bit_cnt <= bit_cnt + 6'd1;      // Next period on falling edge
                else if (bit_cnt == 6'(last_bit))
                    sample_valid <= 1'b1;           // Word complete
            end
            else
            begin
                div_cnt <= div_cnt + div_w'(1);
            end
        end
    end

    // ---------------------------------------------------------------------------
    // Left channel capture, MSB first
    // ---------------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (capture)
        begin
            shift <= {shift[21:0], sd};

            if (bit_cnt == 6'(last_bit))
                sample <= {shift, sd};
        end
    end

endmodule

`default_nettype wire

//--- rtl/level_meter_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_defs.svh"

module level_meter_lane
# (
    parameter int lane_index = 0
)
(
    input  wire                 clk,
    input  wire                 rst_n,

    input  board_pkg::sample_t  sample,
    input  wire                 sample_valid,

    output logic                lit,
    output logic [7:0]          seg
);

    localparam int          hold_w    = $clog2(`HOLD_SAMPLES + 1);
    localparam logic [24:0] threshold = 25'(lane_index + 1) << `LANE_STEP_LOG2;

    logic [23:0]        magnitude;
    logic               exceed;
    logic [hold_w - 1:0] hold_cnt;
    logic [hold_w - 1:0] hold_next;

    // Full scale negative still fits as unsigned
    assign magnitude = sample[23] ? 24'(-sample) : 24'(sample);
    assign exceed    = ({1'b0, magnitude} >= threshold);

    always_comb
    begin
        hold_next = hold_cnt;

        if (exceed)
            hold_next = hold_w'(`HOLD_SAMPLES);     // Restart peak hold
        else if (hold_cnt != '0)
            hold_next = hold_cnt - hold_w'(1);
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            hold_cnt <= '0;
            lit      <= 1'b0;
        end
        else if (sample_valid)
        begin
            hold_cnt <= hold_next;
            lit      <= (hold_next != '0);
        end
    end

    assign seg = lit ? 8'h7f : 8'h00;   // Segments a to g

endmodule

`default_nettype wire

//--- rtl/tm1638_board_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_defs.svh"

module tm1638_board_controller
(
    input  wire                           clk,
    input  wire                           rst_n,

    input  wire                           start,
    input  wire  [`W_LANE - 1:0][7:0]     seg,
    input  wire  [`W_LANE - 1:0]          led,

    output logic                          sio_clk,
    output logic                          sio_stb,
    output logic                          sio_data
);

    import board_pkg::*;

    localparam int div_w         = (`SIO_CLK_DIV > 1) ? $clog2(`SIO_CLK_DIV) : 1;
    localparam int dig_w         = $clog2(`W_LANE);
    localparam int idx_w         = $clog2(2 * `W_LANE + 3);
    localparam int last_data_idx = 2 * `W_LANE + 1;
    localparam int disp_idx      = 2 * `W_LANE + 2;

    localparam logic [2:0] s_idle  = 3'd0,
                           s_latch = 3'd1,
                           s_stb   = 3'd2,
                           s_low   = 3'd3,
                           s_high  = 3'd4,
                           s_end   = 3'd5;

    logic [2:0]                 state;
    logic [div_w - 1:0]         div_cnt;
    logic                       tick;
    logic [idx_w - 1:0]         byte_idx;
    logic [2:0]                 bit_idx;
    logic                       xfer_last;
    logic [7:0]                 shreg;
    logic [`W_LANE - 1:0][7:0]  seg_q;
    logic [`W_LANE - 1:0]       led_q;

    // Byte order: data cmd, address cmd, seg/led pairs, display cmd
    function automatic tm_byte_t build_byte(input logic [idx_w - 1:0] idx);
        tm_byte_t           b;
        logic [idx_w - 1:0] d;

        b = '0;
        d = idx - idx_w'(2);

        if (idx == idx_w'(0))
        begin
            b.cmd.kind  = tm_kind_data;
            b.cmd.field = 6'b000000;                    // Write, auto increment
        end
        else if (idx == idx_w'(1))
        begin
            b.cmd.kind  = tm_kind_address;
            b.cmd.field = 6'b000000;                    // Digit 0
        end
        else if (idx == idx_w'(disp_idx))
        begin
            b.cmd.kind  = tm_kind_display;
            b.cmd.field = {2'b00, 1'b1, 3'd7};          // On, full brightness
        end
        else if (!d[0])
            b.hgfedcba = seg_q[d[dig_w:1]];
        else
            b.hgfedcba = {7'b0, led_q[d[dig_w:1]]};     // Red LED on bit 0

        return b;
    endfunction

    assign tick      = (div_cnt == div_w'(`SIO_CLK_DIV - 1));
    assign xfer_last = (byte_idx == idx_w'(0))
                    || (byte_idx == idx_w'(last_data_idx))
                    || (byte_idx == idx_w'(disp_idx));

    // ---------------------------------------------------------------------------
    // Half period divider for sio_clk
    // ---------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            div_cnt <= '0;
        else if (state == s_idle || state == s_latch || tick)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + div_w'(1);
    end

    // ---------------------------------------------------------------------------
    // Frame sequencer
    // ---------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= s_idle;
            byte_idx <= '0;
            bit_idx  <= '0;
            sio_clk  <= 1'b1;
            sio_stb  <= 1'b1;
            sio_data <= 1'b1;
        end
        else
        begin
            case (state)
                s_idle:
                    if (start)
                        state <= s_latch;       // Lanes update meanwhile

                s_latch:
                begin
                    byte_idx <= '0;
                    state    <= s_stb;
                end

                s_stb:
                    if (tick)
                    begin
                        sio_stb <= 1'b0;
                        bit_idx <= '0;
                        state   <= s_low;
                    end

                s_low:
                    if (tick)
                    begin
                        sio_clk  <= 1'b0;
                        sio_data <= shreg[0];   // LSB first
                        state    <= s_high;
                    end

                s_high:
                    if (tick)
                    begin
                        sio_clk <= 1'b1;        // Display samples here
                        bit_idx <= bit_idx + 3'd1;

                        if (bit_idx != 3'd7)
                            state <= s_low;
                        else if (xfer_last)
                            state <= s_end;
                        else
                        begin
                            byte_idx <= byte_idx + idx_w'(1);
                            state    <= s_low;
                        end
                    end

                s_end:
                    if (tick)
                    begin
                        sio_stb <= 1'b1;

                        if (byte_idx == idx_w'(disp_idx))
                            state <= s_idle;
                        else
                        begin
                            byte_idx <= byte_idx + idx_w'(1);
                            state    <= s_stb;
                        end
                    end

                default:
                    state <= s_idle;
            endcase
        end
    end

    // ---------------------------------------------------------------------------
    // Snapshot and shifter
    // ---------------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (state == s_latch)
        begin
            seg_q <= seg;
            led_q <= led;
        end
    end

    always_ff @(posedge clk)
    begin
        if (tick)
        begin
            if (state == s_stb)
                shreg <= build_byte(byte_idx);
            else if (state == s_high)
            begin
                if (bit_idx == 3'd7 && !xfer_last)
                    shreg <= build_byte(byte_idx + idx_w'(1));  // Next byte, same strobe
                else
                    shreg <= shreg >> 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/board_specific_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_defs.svh"

module board_specific_top
(
    input  wire                  CLK,
    input  wire                  rst_n,

    output wire                  mic_sck,
    output wire                  mic_ws,
    output wire                  mic_lr,
    input  wire                  mic_sd,

    output wire                  sio_clk,
    output wire                  sio_stb,
    output wire                  sio_data,

    output wire  [`W_LANE - 1:0] LED
);

    import board_pkg::*;

    wire clk = CLK;

    sample_t                    sample;
    logic                       sample_valid;
    logic [`W_LANE - 1:0]       lit;
    logic [`W_LANE - 1:0][7:0]  seg;

    // ---------------------------------------------------------------------------
    // Microphone
    // ---------------------------------------------------------------------------

    inmp441_mic_i2s_receiver i_microphone
    (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .sck          ( mic_sck      ),
        .ws           ( mic_ws       ),
        .lr           ( mic_lr       ),
        .sd           ( mic_sd       ),
        .sample       ( sample       ),
        .sample_valid ( sample_valid )
    );

    // ---------------------------------------------------------------------------
    // One meter lane per digit
    // ---------------------------------------------------------------------------

    generate
        genvar i;

        for (i = 0; i < `W_LANE; i ++)
        begin : lane
            level_meter_lane # (.lane_index (i)) i_lane
            (
                .clk          ( clk          ),
                .rst_n        ( rst_n        ),
                .sample       ( sample       ),
                .sample_valid ( sample_valid ),
                .lit          ( lit [i]      ),
                .seg          ( seg [i]      )
            );
        end
    endgenerate

    // ---------------------------------------------------------------------------
    // Display board
    // ---------------------------------------------------------------------------

    tm1638_board_controller i_tm1638
    (
        .clk      ( clk          ),
        .rst_n    ( rst_n        ),
        .start    ( sample_valid ),     // Refresh follows every sample
        .seg      ( seg          ),
        .led      ( lit          ),
        .sio_clk  ( sio_clk      ),
        .sio_stb  ( sio_stb      ),
        .sio_data ( sio_data     )
    );

    assign LED = ~ lit;                 // Board LEDs are active low

endmodule

`default_nettype wire

//--- tb/tb_board_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_defs.svh"

module tb_board_top;

    import board_pkg::*;

    localparam int                   n_samples      = 60;
    localparam int                   frame_clocks   = 128 * `I2S_SCK_DIV;
    localparam int                   timeout_cycles = 70 * frame_clocks;
    localparam int                   quiet_cycles   = 100;   // Gap before the next sample
    localparam int                   slot_periods   = 32;    // sck periods per ws half
    localparam logic [`W_LANE - 1:0] all_dark       = '1;

    logic                   clk;
    logic                   rst_n;
    logic                   mic_sd;
    wire                    mic_sck;
    wire                    mic_ws;
    wire                    mic_lr;
    wire                    sio_clk;
    wire                    sio_stb;
    wire                    sio_data;
    wire  [`W_LANE - 1:0]   led;

    logic [31:0]            lfsr_state;
    int                     error_count;
    int                     check_count;
    int                     cycle_count;
    bit                     timed_out;

    // Microphone side and reference model
    logic                   ws_q;
    logic                   sck_q;
    int                     bit_pos;
    int                     frames_loaded;
    logic                   frame_loaded;
    sample_t                tx_word;
    int                     samples_sent;
    int                     model_hold [`W_LANE];
    int                     lane_hits [`W_LANE];
    int                     lane_releases [`W_LANE];
    logic [`W_LANE - 1:0]   model_lit;
    logic [`W_LANE - 1:0]   exp_lit [n_samples];
    int                     sck_half_clocks;        // Clocks since the last sck edge
    int                     slot_falls;             // Falling sck edges in this ws half
    int                     ws_edges;

    // TM1638 side
    logic                   stb_q;
    logic                   sclk_q;
    logic [7:0]             rx_byte;
    int                     rx_bits;
    logic [7:0]             xfer_bytes [$];
    int                     xfer_pos;               // 0 data, 1 address, 2 display
    int                     refresh_count;

    board_specific_top dut_i
    (
        .CLK      ( clk      ),
        .rst_n    ( rst_n    ),
        .mic_sck  ( mic_sck  ),
        .mic_ws   ( mic_ws   ),
        .mic_lr   ( mic_lr   ),
        .mic_sd   ( mic_sd   ),
        .sio_clk  ( sio_clk  ),
        .sio_stb  ( sio_stb  ),
        .sio_data ( sio_data ),
        .LED      ( led      )
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ---------------------------------------------------------------------------
    // Helpers
    // ---------------------------------------------------------------------------

    function automatic logic lfsr_step();
        logic feedback;

        feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        return feedback;
    endfunction

    function automatic logic [23:0] random_bits(input int count);
        logic [23:0] value;
        int          n;

        value = '0;
        for (n = 0; n < count; n++)
            value = {value[22:0], lfsr_step()};
        return value;
    endfunction

    // Random level with a random attenuation, clipping now and then
    function automatic sample_t make_sample(input int index);
        logic [23:0] raw;
        logic [2:0]  atten;
        sample_t     result;

        if (index % 16 == 15)
            result = 24'h800000;                    // Full scale negative reaches every lane
        else
        begin
            raw   = random_bits(24);
            atten = 3'(random_bits(3));
            if (atten == 3'd7)
                result = raw[23] ? 24'h800000 : 24'h7fffff;
            else
                result = $signed(raw) >>> atten;
        end
        return result;
    endfunction

    task automatic update_meter_model(input sample_t s);
        int value;
        int magnitude;
        int threshold;
        int i;

        value     = s;
        magnitude = (value < 0) ? -value : value;
        for (i = 0; i < `W_LANE; i++)
        begin
            threshold = (i + 1) << `LANE_STEP_LOG2;
            if (magnitude >= threshold)
            begin
                model_hold[i] = `HOLD_SAMPLES;
                lane_hits[i]++;
            end
            else if (model_hold[i] > 0)
            begin
                model_hold[i]--;
                if (model_hold[i] == 0)
                    lane_releases[i]++;
            end
            model_lit[i] = (model_hold[i] != 0);
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        error_count++;
    endtask

    task automatic report_and_finish();
        $display("Summary: %0d checks, %0d errors, %0d samples sent, %0d refreshes seen",
                 check_count, error_count, samples_sent, refresh_count);
        if (error_count == 0 && !timed_out)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    endtask

    // ---------------------------------------------------------------------------
    // Microphone model, one word per left slot
    // ---------------------------------------------------------------------------

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            ws_q         <= 1'b1;                   // First frame starts at release
            sck_q        <= 1'b0;
            bit_pos      <= 0;
            frame_loaded <= 1'b0;
            mic_sd       <= 1'b0;
        end
        else
        begin
            ws_q  <= mic_ws;
            sck_q <= mic_sck;

            if (ws_q && !mic_ws)
            begin
                bit_pos <= 0;
                mic_sd  <= 1'b0;
                if (frames_loaded < n_samples)
                begin
                    tx_word       <= make_sample(frames_loaded);
                    frame_loaded  <= 1'b1;
                    frames_loaded++;
                end
                else
                    frame_loaded <= 1'b0;
            end
            else if (sck_q && !mic_sck && !mic_ws)  // New bit after falling sck
            begin
                bit_pos <= bit_pos + 1;
                if (frame_loaded && bit_pos < 24)
                    mic_sd <= tx_word[23 - bit_pos];
                else
                    mic_sd <= 1'b0;

                if (frame_loaded && bit_pos == 23)
                begin
                    update_meter_model(tx_word);
                    exp_lit[samples_sent] <= model_lit;
                    samples_sent          <= samples_sent + 1;
                end
            end
        end
    end

    // ---------------------------------------------------------------------------
    // I2S clocks, sck half period and ws slot length
    // ---------------------------------------------------------------------------

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            sck_half_clocks <= 0;
            slot_falls      <= 0;
            ws_edges        <= 0;
        end
        else
        begin
            sck_half_clocks <= sck_half_clocks + 1;
            if (sck_q != mic_sck)
            begin
                check_count++;
                if (sck_half_clocks != `I2S_SCK_DIV)
                    report_error($sformatf("sck half period is %0d clocks, expected %0d",
                                           sck_half_clocks, `I2S_SCK_DIV));
                sck_half_clocks <= 1;
            end

            if (ws_q != mic_ws)
            begin
                if (ws_edges > 0)                   // First edge is the release
                begin
                    check_count++;
                    if (slot_falls + int'(sck_q && !mic_sck) != slot_periods)
                        report_error($sformatf("ws half lasted %0d sck periods, expected %0d",
                                               slot_falls + int'(sck_q && !mic_sck),
                                               slot_periods));
                end
                ws_edges   <= ws_edges + 1;
                slot_falls <= 0;
            end
            else if (sck_q && !mic_sck)
                slot_falls <= slot_falls + 1;
        end
    end

    // ---------------------------------------------------------------------------
    // TM1638 model and checks
    // ---------------------------------------------------------------------------

    task automatic check_led_at_strobe();
        logic [`W_LANE - 1:0] lit_exp;

        check_count++;
        if (refresh_count >= samples_sent)
            report_error($sformatf("transfer began without a new sample, refresh %0d",
                                   refresh_count));
        else
        begin
            lit_exp = exp_lit[refresh_count];
            if (led !== ~lit_exp)
                report_error($sformatf("LED is %b, expected %b", led, ~lit_exp));
        end
        rx_bits = 0;
        xfer_bytes.delete();
    endtask

    task automatic shift_in_bit(input logic data);
        rx_byte = {data, rx_byte[7:1]};             // LSB arrives first
        rx_bits++;
        if (rx_bits == 8)
        begin
            xfer_bytes.push_back(rx_byte);
            rx_bits = 0;
        end
    endtask

    task automatic check_command_byte(input tm_byte_t b, input logic [7:0] expected,
                                      input string name);
        check_count++;
        if (b !== expected)
            report_error($sformatf("%s of refresh %0d is %h (kind %b field %h), expected %h",
                                   name, refresh_count, b, b.cmd.kind, b.cmd.field, expected));
    endtask

    task automatic check_single_command(input logic [7:0] expected, input string name);
        check_count++;
        if (xfer_bytes.size() != 1)
            report_error($sformatf("%s transfer of refresh %0d has %0d bytes, expected 1",
                                   name, refresh_count, xfer_bytes.size()));
        else
            check_command_byte(xfer_bytes[0], expected, name);
    endtask

    task automatic check_transfer();
        logic [`W_LANE - 1:0] lit_exp;
        logic [7:0]           seg_exp;
        tm_byte_t             b;
        int                   i;

        check_count++;
        if (rx_bits != 0)
            report_error($sformatf("transfer ended with %0d stray bits", rx_bits));

        lit_exp = (refresh_count < samples_sent) ? exp_lit[refresh_count] : '0;

        case (xfer_pos)
            0:
                check_single_command(8'h40, "data command");
            1:
            begin
                check_count++;
                if (xfer_bytes.size() != 2 * `W_LANE + 1)
                    report_error($sformatf("address transfer has %0d bytes, expected %0d",
                                           xfer_bytes.size(), 2 * `W_LANE + 1));
                else
                begin
                    check_command_byte(xfer_bytes[0], 8'hc0, "address command");
                    for (i = 0; i < `W_LANE; i++)
                    begin
                        seg_exp = lit_exp[i] ? 8'h7f : 8'h00;
                        b       = xfer_bytes[1 + 2 * i];
                        check_count++;
                        if (b.hgfedcba !== seg_exp)
                            report_error($sformatf("refresh %0d digit %0d segments %h, expected %h",
                                                   refresh_count, i, b.hgfedcba, seg_exp));
                        b = xfer_bytes[2 + 2 * i];
                        check_count++;
                        if (b.hgfedcba !== {7'b0, lit_exp[i]})
                            report_error($sformatf("refresh %0d LED byte %0d is %h, expected %h",
                                                   refresh_count, i, b.hgfedcba,
                                                   {7'b0, lit_exp[i]}));
                    end
                end
            end
            default:
            begin
                check_single_command(8'h8f, "display command");
                refresh_count++;
            end
        endcase

        xfer_pos = (xfer_pos + 1) % 3;
        xfer_bytes.delete();
        rx_bits = 0;
    endtask

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            stb_q  <= 1'b1;
            sclk_q <= 1'b1;
            if (cycle_count > 0)                    // Outputs settle at the first edge
            begin
                check_count++;
                if (sio_stb !== 1'b1 || sio_clk !== 1'b1 || led !== all_dark)
                    report_error($sformatf("in reset sio_stb %b sio_clk %b LED %b",
                                           sio_stb, sio_clk, led));
            end
        end
        else
        begin
            stb_q  <= sio_stb;
            sclk_q <= sio_clk;

            check_count++;
            if (mic_lr !== 1'b0)
                report_error("mic_lr is not driven low");

            if (samples_sent == 0)
            begin
                check_count++;
                if (led !== all_dark || sio_stb !== 1'b1)
                    report_error($sformatf("idle LED %b sio_stb %b before first sample",
                                           led, sio_stb));
            end

            if (stb_q && !sio_stb)
                check_led_at_strobe();
            if (!sclk_q && sio_clk && !sio_stb)
                shift_in_bit(sio_data);
            if (!stb_q && sio_stb)
                check_transfer();
        end
    end

    // ---------------------------------------------------------------------------
    // Timeout
    // ---------------------------------------------------------------------------

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles)
        begin
            $display("Timeout after %0d cycles, %0d of %0d refreshes seen",
                     cycle_count, refresh_count, n_samples);
            timed_out = 1'b1;
            report_and_finish();
        end
    end

    // ---------------------------------------------------------------------------
    // Main sequence
    // ---------------------------------------------------------------------------

    initial
    begin
        int i;

        lfsr_state    = 32'h3e9ec7d7;
        rst_n         = 1'b0;
        mic_sd        = 1'b0;
        error_count   = 0;
        check_count   = 0;
        cycle_count   = 0;
        timed_out     = 1'b0;
        frames_loaded = 0;
        samples_sent  = 0;
        model_lit     = '0;
        rx_byte       = '0;
        rx_bits       = 0;
        xfer_pos      = 0;
        refresh_count = 0;
        for (i = 0; i < `W_LANE; i++)
        begin
            model_hold[i]    = 0;
            lane_hits[i]     = 0;
            lane_releases[i] = 0;
        end

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        wait (refresh_count == n_samples);
        repeat (quiet_cycles) @(posedge clk);       // Any extra refresh would start here

        check_count++;
        if (refresh_count != samples_sent || samples_sent != n_samples)
            report_error($sformatf("%0d refreshes for %0d samples, %0d planned",
                                   refresh_count, samples_sent, n_samples));
        check_count++;
        if (xfer_pos != 0 || xfer_bytes.size() != 0 || rx_bits != 0)
            report_error("a refresh was left unfinished");

        for (i = 0; i < `W_LANE; i++)
            $display("Lane %0d: %0d crossings, %0d hold releases",
                     i, lane_hits[i], lane_releases[i]);

        report_and_finish();
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+rtl
rtl/board_pkg.sv
rtl/inmp441_mic_i2s_receiver.sv
rtl/level_meter_lane.sv
rtl/tm1638_board_controller.sv
rtl/board_specific_top.sv
tb/tb_board_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line in the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_board_top \
    -o tb_board_top \
    && ./obj_dir/tb_board_top | tee sim.log \
    || { echo "Build or simulation did not complete"; exit 1; }

grep -q "^TESTBENCH PASSED$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
